/* conv_accel.f */
+incdir+include
hw/conv_pkg.sv
hw/shared_mem.sv
hw/config_loader.sv
hw/conv_engine.sv
hw/conv_accel.sv
bench/conv_accel_properties.sv
bench/conv_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_accel_tb -f conv_accel.f --Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vconv_accel_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* bench/conv_accel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_accel_tb;
	localparam int TIMEOUT_CYCLES = 30 * 60 + 200 * 6; // 60 outputs over six tests

	logic clk;
	logic rst_n;
	logic start;
	logic host_wr_en;
	logic host_rd_en;
	conv_pkg::addr_t host_addr;
	conv_pkg::word_t host_wdata;
	logic busy;
	logic done;
	conv_pkg::word_t host_rdata;
	logic host_rd_valid;

	int cycles = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int done_count = 0;

	byte coef [9];
	byte unsigned pix [256];
	int img_w;
	int img_h;
	conv_pkg::addr_t img_base;
	conv_pkg::addr_t res_base;

	conv_accel u_dut (
		.clk(clk), .rst_n(rst_n), .start(start),
		.host_wr_en(host_wr_en), .host_rd_en(host_rd_en),
		.host_addr(host_addr), .host_wdata(host_wdata),
		.busy(busy), .done(done),
		.host_rdata(host_rdata), .host_rd_valid(host_rd_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a run never finished", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	always @(negedge clk)
		if (done)
			done_count++;

	// host tasks start and end on a falling edge
	task automatic host_write(input conv_pkg::addr_t addr, input conv_pkg::word_t data);
		host_wr_en = 1'b1;
		host_addr = addr;
		host_wdata = data;
		@(negedge clk);
		host_wr_en = 1'b0;
	endtask

	task automatic host_read(input conv_pkg::addr_t addr, output conv_pkg::word_t data);
		host_rd_en = 1'b1;
		host_addr = addr;
		@(negedge clk);
		host_rd_en = 1'b0;
		data = host_rdata;
		if (!host_rd_valid) begin
			$display("host_rd_valid missing one cycle after the read of 0x%h at %0t",
				addr, $time);
			errors++;
		end
	endtask

	task automatic expect_word(input conv_pkg::addr_t addr, input conv_pkg::word_t exp);
		conv_pkg::word_t got;
		host_read(addr, got);
		if (got !== exp) begin
			$display("ERROR at %0t: word at 0x%h is %0d, expected %0d",
				$time, addr, $signed(got), $signed(exp));
			errors++;
		end
	endtask

	// valid 3x3 convolution of output k in raster order
	function automatic int ref_conv(input int k);
		int x;
		int y;
		int s;
		x = k % (img_w - 2);
		y = k / (img_w - 2);
		s = 0;
		for (int r = 0; r < 3; r++)
			for (int c = 0; c < 3; c++)
				s += int'(pix[(y + r) * img_w + x + c]) * int'(coef[3 * r + c]);
		return s;
	endfunction

	task automatic random_pixels();
		foreach (pix[i])
			pix[i] = 8'($urandom());
	endtask

	task automatic random_filter();
		foreach (coef[i])
			coef[i] = 8'($urandom());
	endtask

	task automatic load_image();
		conv_pkg::word_t w;
		for (int i = 0; i < img_w * img_h; i++) begin
			w = $urandom();
			w[7:0] = pix[i]; // upper bytes are junk
			host_write(img_base + 4 * i, w);
		end
	endtask

	task automatic load_config();
		host_write(`CFG_FILTER_ADDR, {coef[0], coef[1], coef[2], coef[3]});
		host_write(`CFG_FILTER_ADDR + 4, {coef[4], coef[5], coef[6], coef[7]});
		host_write(`CFG_FILTER_ADDR + 8, {coef[8], 24'h5a5a5a});
		host_write(`CFG_DIMS_ADDR, {16'(img_w), 16'(img_h)});
		host_write(`CFG_START_ADDR, img_base);
		host_write(`CFG_RESULT_ADDR, res_base);
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (!busy) begin
			$display("ERROR at %0t: busy low one cycle after start", $time);
			errors++;
		end
	endtask

	task automatic wait_done();
		while (!done)
			@(negedge clk);
	endtask

	task automatic check_results();
		for (int k = 0; k < (img_w - 2) * (img_h - 2); k++)
			expect_word(res_base + 4 * k, ref_conv(k));
	endtask

	task automatic set_job(input int w, input int h, input conv_pkg::addr_t base,
		input conv_pkg::addr_t res);
		img_w = w;
		img_h = h;
		img_base = base;
		res_base = res;
	endtask

	task automatic run_job();
		load_image();
		load_config();
		pulse_start();
		wait_done();
		check_results();
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
			$display("test %s: FAILED", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic test_host_access();
		int e0;
		conv_pkg::word_t w;
		e0 = errors;
		if (busy || done) begin
			$display("ERROR at %0t: busy %b done %b after reset", $time, busy, done);
			errors++;
		end
		w = $urandom();
		host_write(32'h0000_0ff0, w);
		expect_word(32'h0000_0ff0, w);
		@(negedge clk);
		if (host_rd_valid) begin
			$display("host_rd_valid stayed high past one cycle at %0t", $time);
			errors++;
		end
		report_test("host_access", e0);
	endtask

	task automatic test_identity();
		int e0;
		e0 = errors;
		foreach (coef[i])
			coef[i] = 0;
		coef[4] = 1; // center tap passes the interior through
		random_pixels();
		set_job(6, 5, 32'h100, 32'h200);
		run_job();
		report_test("identity_6x5", e0);
	endtask

	task automatic test_random_filter();
		int e0;
		e0 = errors;
		random_filter();
		coef[4] = -100; // pulls most sums negative
		random_pixels();
		set_job(8, 7, 32'h400, 32'h600);
		run_job();
		report_test("random_8x7", e0);
	endtask

	task automatic test_single_output();
		int e0;
		e0 = errors;
		random_filter();
		random_pixels();
		set_job(3, 3, 32'h100, 32'h200);
		host_write(32'h204, 32'hc0ff_ee11); // guard word after the only result
		run_job();
		expect_word(32'h204, 32'hc0ff_ee11);
		report_test("single_3x3", e0);
	endtask

	task automatic test_busy_lockout();
		int e0;
		int n0;
		int n;
		conv_pkg::word_t got;
		e0 = errors;
		random_filter();
		random_pixels();
		set_job(5, 5, 32'h100, 32'h200);
		load_image();
		load_config();
		n0 = done_count;
		pulse_start();
		start = 1'b1; // held through the whole run
		n = 0;
		while (!done) begin
			host_write(img_base + 4 * n, {24'h0, ~pix[n]}); // every cycle of the run
			n = (n + 1) % (img_w * img_h);
		end
		start = 1'b0;
		check_results();
		for (int i = 0; i < img_w * img_h; i++) begin
			host_read(img_base + 4 * i, got);
			if (got[7:0] !== pix[i]) begin
				$display("ERROR at %0t: pixel %0d is 0x%h, expected 0x%h",
					$time, i, got[7:0], pix[i]);
				errors++;
			end
		end
		repeat (20) @(negedge clk);
		if (done_count != n0 + 1 || busy) begin
			$display("ERROR at %0t: %0d done pulses, busy %b", $time, done_count - n0, busy);
			errors++;
		end
		report_test("busy_lockout", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		int old_exp [4];
		e0 = errors;
		random_filter();
		random_pixels();
		set_job(4, 4, 32'h100, 32'h300);
		run_job();
		foreach (old_exp[k])
			old_exp[k] = ref_conv(k);
		random_filter();
		res_base = 32'h380;
		load_config(); // image stays in place
		pulse_start();
		wait_done();
		check_results();
		foreach (old_exp[k])
			expect_word(32'h300 + 4 * k, old_exp[k]);
		report_test("back_to_back", e0);
	endtask

	initial begin
		void'($urandom(32'ha9bab874));
		rst_n = 1'b0;
		start = 1'b0;
		host_wr_en = 1'b0;
		host_rd_en = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_host_access();
		test_identity();
		test_random_filter();
		test_single_output();
		test_busy_lockout();
		test_back_to_back();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/conv_accel_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accel_properties (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic done,
	input logic cfg_busy,
	input logic eng_busy,
	input logic eng_wr_en,
	input logic mem_rd_valid
);
	logic [3:0] taps_seen; // engine reads returned since the last result write

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			taps_seen <= '0;
		else if (eng_wr_en || !eng_busy)
			taps_seen <= '0;
		else if (mem_rd_valid)
			taps_seen <= taps_seen + 4'd1;
	end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done held for more than one cycle");

	one_phase: assert property (@(posedge clk) disable iff (!rst_n) !(cfg_busy && eng_busy))
		else $error("loader and engine both own the memory");

	phase_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(cfg_busy || eng_busy) |-> busy)
		else $error("phase active while busy is low");

	// result write lands with the ninth returning tap
	write_after_taps: assert property (@(posedge clk) disable iff (!rst_n)
		eng_wr_en |-> mem_rd_valid && taps_seen == 4'd8)
		else $error("engine write without nine returned taps");

endmodule

bind conv_accel conv_accel_properties u_props (
	.clk(clk), .rst_n(rst_n), .busy(busy), .done(done),
	.cfg_busy(cfg_busy), .eng_busy(eng_busy),
	.eng_wr_en(eng_wr_en),
	.mem_rd_valid(mem_rd_valid)
);

`default_nettype wire

/* hw/conv_accel.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accel (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic host_wr_en,
	input logic host_rd_en,
	input conv_pkg::addr_t host_addr,
	input conv_pkg::word_t host_wdata,
	output logic busy,
	output logic done,
	output conv_pkg::word_t host_rdata,
	output logic host_rd_valid
);
	typedef enum logic [1:0] {
		S_IDLE,
		S_CONFIG,
		S_COMPUTE
	} state_e;

	state_e state;

	logic load_start;
	logic eng_start;
	logic cfg_done;
	logic eng_done;
	logic cfg_busy;
	logic eng_busy;
	logic cfg_rd_en;
	conv_pkg::addr_t cfg_addr;
	logic eng_rd_en;
	logic eng_wr_en;
	conv_pkg::addr_t eng_addr;
	conv_pkg::word_t eng_wdata;
	conv_pkg::word_t mem_rdata;
	logic mem_rd_valid;
	conv_pkg::filter_t filter;
	conv_pkg::dim_t img_width;
	conv_pkg::dim_t img_height;
	conv_pkg::addr_t start_addr;
	conv_pkg::addr_t result_addr;
	logic host_wr_ok;
	logic host_rd_ok;
	logic host_rd_q; // host read in flight

	assign busy = (state != S_IDLE);
	assign host_wr_ok = host_wr_en && !busy; // host locked out during a run
	assign host_rd_ok = host_rd_en && !busy;
	assign host_rdata = mem_rdata;
	assign host_rd_valid = mem_rd_valid && host_rd_q;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			load_start <= 1'b0;
			eng_start <= 1'b0;
			done <= 1'b0;
			host_rd_q <= 1'b0;
		end else begin
			load_start <= 1'b0;
			eng_start <= 1'b0;
			done <= 1'b0;
			host_rd_q <= host_rd_ok;
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_CONFIG;
						load_start <= 1'b1;
					end
				end
				S_CONFIG: begin
					if (cfg_done) begin
						state <= S_COMPUTE;
						eng_start <= 1'b1;
					end
				end
				default: begin
					if (eng_done) begin
						state <= S_IDLE;
						done <= 1'b1;
					end
				end
			endcase
		end
	end

	shared_mem u_mem (
		.clk(clk), .rst_n(rst_n),
		.cfg_busy(cfg_busy), .eng_busy(eng_busy),
		.host_wr_en(host_wr_ok), .host_rd_en(host_rd_ok),
		.host_addr(host_addr), .host_wdata(host_wdata),
		.cfg_rd_en(cfg_rd_en), .cfg_addr(cfg_addr),
		.eng_rd_en(eng_rd_en), .eng_wr_en(eng_wr_en),
		.eng_addr(eng_addr), .eng_wdata(eng_wdata),
		.rdata(mem_rdata), .rd_valid(mem_rd_valid)
	);

	config_loader u_loader (
		.clk(clk), .rst_n(rst_n),
		.load_start(load_start), .rd_valid(mem_rd_valid), .rdata(mem_rdata),
		.cfg_rd_en(cfg_rd_en), .cfg_addr(cfg_addr),
		.cfg_busy(cfg_busy), .cfg_done(cfg_done),
		.filter(filter), .img_width(img_width), .img_height(img_height),
		.start_addr(start_addr), .result_addr(result_addr)
	);

	conv_engine u_engine (
		.clk(clk), .rst_n(rst_n),
		.eng_start(eng_start), .filter(filter),
		.img_width(img_width), .img_height(img_height),
		.start_addr(start_addr), .result_addr(result_addr),
		.rd_valid(mem_rd_valid), .rdata(mem_rdata),
		.eng_rd_en(eng_rd_en), .eng_wr_en(eng_wr_en),
		.eng_addr(eng_addr), .eng_wdata(eng_wdata),
		.eng_busy(eng_busy), .eng_done(eng_done)
	);

endmodule

`default_nettype wire

/* hw/conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_engine (
	input logic clk,
	input logic rst_n,
	input logic eng_start,
	input conv_pkg::filter_t filter,
	input conv_pkg::dim_t img_width,
	input conv_pkg::dim_t img_height,
	input conv_pkg::addr_t start_addr,
	input conv_pkg::addr_t result_addr,
	input logic rd_valid,
	input conv_pkg::word_t rdata,
	output logic eng_rd_en,
	output logic eng_wr_en,
	output conv_pkg::addr_t eng_addr,
	output conv_pkg::word_t eng_wdata,
	output logic eng_busy,
	output logic eng_done
);
	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_LAST,
		S_DONE
	} state_e;

	state_e state;

	conv_pkg::dim_t x; // output column
	conv_pkg::dim_t y; // output row
	logic [1:0] r; // window row of the next read
	logic [1:0] c; // window column of the next read
	logic [3:0] data_tap; // tap of the returning data
	conv_pkg::word_t out_count;
	conv_pkg::acc_t acc;

	conv_pkg::pixel_t pixel;
	conv_pkg::coeff_t coeff;
	conv_pkg::acc_t prod;
	conv_pkg::acc_t sum;
	conv_pkg::word_t row_idx;
	conv_pkg::word_t pix_idx;
	conv_pkg::addr_t pix_addr;
	conv_pkg::addr_t res_addr;
	logic last_col;
	logic last_row;
	logic too_small;

	assign pixel = rdata[7:0];
	assign coeff = filter[data_tap];
	assign prod = $signed({1'b0, pixel}) * coeff; // signed 9x8 product
	assign sum = ((data_tap == 4'd0) ? '0 : acc) + prod;

	assign row_idx = conv_pkg::word_t'(y) + conv_pkg::word_t'(r);
	assign pix_idx = row_idx * conv_pkg::word_t'(img_width) + conv_pkg::word_t'(x)
		+ conv_pkg::word_t'(c);
	assign pix_addr = start_addr + (pix_idx << 2);
	assign res_addr = result_addr + (out_count << 2);

	assign last_col = (x == img_width - 16'd3);
	assign last_row = (y == img_height - 16'd3);
	assign too_small = (img_width < 16'd3) || (img_height < 16'd3);

	assign eng_rd_en = (state == S_READ);
	assign eng_wr_en = (state == S_LAST) && rd_valid; // ninth tap returns here
	assign eng_addr = (state == S_LAST) ? res_addr : pix_addr;
	assign eng_wdata = sum;
	assign eng_busy = (state != S_IDLE);
	assign eng_done = (state == S_DONE);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			x <= '0;
			y <= '0;
			r <= '0;
			c <= '0;
			data_tap <= '0;
			out_count <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (eng_start) begin
						x <= '0;
						y <= '0;
						r <= '0;
						c <= '0;
						data_tap <= '0;
						out_count <= '0;
						state <= too_small ? S_DONE : S_READ; // no outputs below 3x3
					end
				end
				S_READ: begin
					if (rd_valid)
						data_tap <= data_tap + 4'd1;
					if (c == 2'd2) begin
						c <= '0;
						if (r == 2'd2) begin
							r <= '0;
							state <= S_LAST;
						end else begin
							r <= r + 2'd1;
						end
					end else begin
						c <= c + 2'd1;
					end
				end
				S_LAST: begin
					if (rd_valid) begin
						data_tap <= '0;
						out_count <= out_count + 32'd1;
						if (last_col) begin
							x <= '0;
							if (last_row) begin
								state <= S_DONE;
							end else begin
								y <= y + 16'd1;
								state <= S_READ;
							end
						end else begin
							x <= x + 16'd1;
							state <= S_READ;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_READ && rd_valid)
			acc <= sum;
	end

endmodule

`default_nettype wire

/* hw/config_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module config_loader (
	input logic clk,
	input logic rst_n,
	input logic load_start,
	input logic rd_valid,
	input conv_pkg::word_t rdata,
	output logic cfg_rd_en,
	output conv_pkg::addr_t cfg_addr,
	output logic cfg_busy,
	output logic cfg_done,
	output conv_pkg::filter_t filter,
	output conv_pkg::dim_t img_width,
	output conv_pkg::dim_t img_height,
	output conv_pkg::addr_t start_addr,
	output conv_pkg::addr_t result_addr
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_FILTER1,
		S_FILTER2,
		S_FILTER3,
		S_DIMS,
		S_START,
		S_RESULT,
		S_DONE
	} state_e;

	state_e state;
	state_e next_load;
	logic rd_pending; // read issued, data not yet back
	logic in_load;
	logic capture;

	assign in_load = (state != S_IDLE) && (state != S_DONE);
	assign capture = in_load && rd_pending && rd_valid;

	// first read goes out together with load_start
	assign cfg_rd_en = (state == S_IDLE && load_start) || (in_load && !rd_pending);
	assign cfg_busy = (state != S_IDLE) || load_start;
	assign cfg_done = (state == S_DONE);

	always_comb begin
		case (state)
			S_FILTER2: cfg_addr = `CFG_FILTER_ADDR + 32'd4;
			S_FILTER3: cfg_addr = `CFG_FILTER_ADDR + 32'd8;
			S_DIMS: cfg_addr = `CFG_DIMS_ADDR;
			S_START: cfg_addr = `CFG_START_ADDR;
			S_RESULT: cfg_addr = `CFG_RESULT_ADDR;
			default: cfg_addr = `CFG_FILTER_ADDR; // idle and first word
		endcase
	end

	always_comb begin
		case (state)
			S_FILTER1: next_load = S_FILTER2;
			S_FILTER2: next_load = S_FILTER3;
			S_FILTER3: next_load = S_DIMS;
			S_DIMS: next_load = S_START;
			S_START: next_load = S_RESULT;
			default: next_load = S_DONE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			rd_pending <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (load_start) begin
						state <= S_FILTER1;
						rd_pending <= 1'b1;
					end
				end
				S_DONE: state <= S_IDLE;
				default: begin
					if (!rd_pending) begin
						rd_pending <= 1'b1;
					end else if (rd_valid) begin
						rd_pending <= 1'b0;
						state <= next_load;
					end
				end
			endcase
		end
	end

	// decoded fields, held until the next load
	always_ff @(posedge clk) begin
		if (capture) begin
			case (state)
				S_FILTER1: for (int i = 0; i < 4; i++) filter[i] <= rdata[31-8*i -: 8];
				S_FILTER2: for (int i = 0; i < 4; i++) filter[4+i] <= rdata[31-8*i -: 8];
				S_FILTER3: filter[8] <= rdata[31:24]; // low bytes unused
				S_DIMS: begin
					img_width <= rdata[31:16];
					img_height <= rdata[15:0];
				end
				S_START: start_addr <= rdata;
				S_RESULT: result_addr <= rdata;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/shared_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module shared_mem (
	input logic clk,
	input logic rst_n,
	input logic cfg_busy,
	input logic eng_busy,
	input logic host_wr_en,
	input logic host_rd_en,
	input conv_pkg::addr_t host_addr,
	input conv_pkg::word_t host_wdata,
	input logic cfg_rd_en,
	input conv_pkg::addr_t cfg_addr,
	input logic eng_rd_en,
	input logic eng_wr_en,
	input conv_pkg::addr_t eng_addr,
	input conv_pkg::word_t eng_wdata,
	output conv_pkg::word_t rdata,
	output logic rd_valid
);
	conv_pkg::word_t mem [`MEM_WORDS];

	logic sel_rd;
	logic sel_wr;
	conv_pkg::addr_t sel_addr;
	conv_pkg::word_t sel_wdata;
	logic [`MEM_AW-1:0] widx;

	// owner follows the active phase
	always_comb begin
		if (eng_busy) begin
			sel_rd = eng_rd_en;
			sel_wr = eng_wr_en;
			sel_addr = eng_addr;
			sel_wdata = eng_wdata;
		end else if (cfg_busy) begin
			sel_rd = cfg_rd_en;
			sel_wr = 1'b0; // loader only reads
			sel_addr = cfg_addr;
			sel_wdata = '0;
		end else begin
			sel_rd = host_rd_en;
			sel_wr = host_wr_en;
			sel_addr = host_addr;
			sel_wdata = host_wdata;
		end
	end

	assign widx = sel_addr[`MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (sel_wr)
			mem[widx] <= sel_wdata;
		if (sel_rd)
			rdata <= mem[widx];
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= sel_rd;
	end

endmodule

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t; // word aligned byte address

	typedef logic signed [7:0] coeff_t;
	typedef coeff_t [0:8] filter_t; // row-major window order

	typedef logic [7:0] pixel_t; // low byte of a memory word
	typedef logic [15:0] dim_t;
	typedef logic signed [31:0] acc_t;

endpackage

`default_nettype wire

/* include/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

`define MEM_WORDS 1024 // shared memory depth in words
`define MEM_AW 10 // word index width

// configuration block, byte addresses
`define CFG_FILTER_ADDR 32'h0000_0000 // three packed coefficient words
`define CFG_DIMS_ADDR 32'h0000_000C // width in 31..16, height in 15..0
`define CFG_START_ADDR 32'h0000_0010 // first image pixel
`define CFG_RESULT_ADDR 32'h0000_0014 // first result word

`endif
